// ==== hw/csr_isa_pkg.sv ====
`default_nettype none

package csr_isa_pkg;

	//////////////////////////////////////////////////
	// CSR instruction opcodes
	//////////////////////////////////////////////////

	// Register and immediate forms from decode
	typedef enum logic [2:0] {
		CSRRW  = 3'd0, // swap with rs1
		CSRRS  = 3'd1, // set bits from rs1
		CSRRC  = 3'd2, // clear bits from rs1
		CSRRWI = 3'd3, // swap with uimm
		CSRRSI = 3'd4, // set bits from uimm
		CSRRCI = 3'd5  // clear bits from uimm
	} csr_op_e;

	// Execute function, immediate forms folded in
	typedef enum logic [1:0] {
		FUNC_RW = 2'd0,
		FUNC_RS = 2'd1,
		FUNC_RC = 2'd2
	} csr_func_e;

	//////////////////////////////////////////////////
	// Implemented machine CSR addresses
	//////////////////////////////////////////////////

	localparam logic [11:0] CSR_MTVEC    = 12'h305; // trap vector base
	localparam logic [11:0] CSR_MSCRATCH = 12'h340; // scratch for trap handler
	localparam logic [11:0] CSR_MEPC     = 12'h341; // exception PC
	localparam logic [11:0] CSR_MCAUSE   = 12'h342; // trap cause

endpackage

`default_nettype wire

// ==== hw/csr_pipe_pkg.sv ====
`default_nettype none

package csr_pipe_pkg;

	//////////////////////////////////////////////////
	// Pipeline payloads
	//////////////////////////////////////////////////

	// One dispatched CSR instruction, 89 bits
	typedef struct packed {
		csr_isa_pkg::csr_op_e op;
		logic [63:0]          pc;   // for commit ordering
		logic [11:0]          addr; // CSR address
		logic [4:0]           rd;
		logic [4:0]           rs1;  // uimm for the I forms
	} csr_issue_info_t;

	// Issued operation to execute, 25 bits
	typedef struct packed {
		csr_isa_pkg::csr_func_e func;
		logic                   is_imm; // rs1 field is the operand itself
		logic [11:0]            addr;
		logic [4:0]             rd;
		logic [4:0]             rs1;
	} csr_exeparam_t;

	// Writeback result, old CSR value to rd
	typedef struct packed {
		logic [4:0]  rd;
		logic [63:0] data;
	} csr_wb_t;

	// Issue FSM
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0, // waiting for an entry
		ST_CHECK = 2'd1, // head present, hazards being checked
		ST_EXEC  = 2'd2  // issued, waiting for writeback
	} issue_state_e;

endpackage

`default_nettype wire

// ==== hw/csr_issue_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_issue_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire                           CLK,
	input  wire                           reset,
	input  wire                           flush,
	input  wire                           push,
	input  csr_pipe_pkg::csr_issue_info_t push_info,
	input  wire                           pop,
	output logic                          empty,
	output csr_pipe_pkg::csr_issue_info_t head,
	output logic                          credit
);
	import csr_pipe_pkg::*;

	localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	csr_issue_info_t mem [FIFO_DEPTH]; // payload only, no reset
	logic [PW-1:0] wr_ptr, rd_ptr;
	logic [CW-1:0] count;
	logic          full;
	logic          do_push, do_pop;

	// Wrap at depth, works for any depth
	function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
		ptr_inc = (p == PW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full    = (count == CW'(FIFO_DEPTH));
	assign empty   = (count == '0);
	assign do_push = push & ~full; // overflow dropped
	assign do_pop  = pop & ~empty;
	assign head    = mem[rd_ptr];

	always_ff @(posedge CLK) begin
		if (do_push) mem[wr_ptr] <= push_info;
	end

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // idle or push+pop
			endcase
		end
	end

	// One credit back to dispatch per freed slot
	always_ff @(posedge CLK) begin
		if (reset) credit <= 1'b0;
		else       credit <= do_pop;
	end

endmodule

`default_nettype wire

// ==== hw/csr_credit_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_credit_counter #(
	parameter int WB_CREDITS = 2
) (
	input  wire  CLK,
	input  wire  reset,
	input  wire  take, // issue reserves a slot
	input  wire  give, // consumer drained a result
	output logic available
);

	localparam int CW = $clog2(WB_CREDITS + 1);
	localparam logic [CW-1:0] MAX = CW'(WB_CREDITS);

	logic [CW-1:0] count;

	always_ff @(posedge CLK) begin
		if (reset) begin
			count <= MAX; // full credit after reset
		end else if (take && !give) begin
			if (count != '0) count <= count - 1'b1; // floor at zero
		end else if (give && !take) begin
			if (count != MAX) count <= count + 1'b1; // cap at initial
		end
		// take and give together leave it as is
	end

	assign available = (count != '0);

endmodule

`default_nettype wire

// ==== hw/csr_issue.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_issue (
	input  wire                           CLK,
	input  wire                           reset,
	input  wire                           flush,
	input  wire                           fifo_empty,
	input  csr_pipe_pkg::csr_issue_info_t fifo_head,
	output logic                          fifo_pop,
	input  wire  [31:0]                   wb_log,
	input  wire  [63:0]                   commit_pc,
	input  wire                           credit_ok,
	output logic                          credit_take,
	output logic                          exe_valid,
	output csr_pipe_pkg::csr_exeparam_t   exe_param,
	input  wire                           wb_done
);
	import csr_isa_pkg::*;
	import csr_pipe_pkg::*;

	issue_state_e state_q, state_d;
	logic          head_imm;
	logic          order_ok, rs1_ok, issue;
	csr_exeparam_t param_d;

	//////////////////////////////////////////////////
	// Hazard checks on the queue head
	//////////////////////////////////////////////////

	assign head_imm = (fifo_head.op == CSRRWI) || (fifo_head.op == CSRRSI) ||
	                  (fifo_head.op == CSRRCI);
	assign order_ok = (commit_pc == fifo_head.pc); // all older ones retired
	assign rs1_ok   = head_imm || (fifo_head.rs1 == 5'd0) || wb_log[fifo_head.rs1];

	assign issue = (state_q == ST_CHECK) && !fifo_empty && order_ok && rs1_ok &&
	               credit_ok && !flush;

	assign fifo_pop    = issue;
	assign credit_take = issue; // one writeback slot per issue

	// Fold opcode into execute function
	always_comb begin
		param_d.is_imm = head_imm;
		param_d.addr   = fifo_head.addr;
		param_d.rd     = fifo_head.rd;
		param_d.rs1    = fifo_head.rs1;
		case (fifo_head.op)
			CSRRS, CSRRSI: param_d.func = FUNC_RS;
			CSRRC, CSRRCI: param_d.func = FUNC_RC;
			default:       param_d.func = FUNC_RW; // CSRRW and CSRRWI
		endcase
	end

	//////////////////////////////////////////////////
	// State machine
	//////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:  if (!fifo_empty) state_d = ST_CHECK;
			ST_CHECK: begin
				if (issue)           state_d = ST_EXEC;
				else if (fifo_empty) state_d = ST_IDLE;
			end
			ST_EXEC:  if (wb_done) state_d = ST_IDLE; // CSR file already updated
			default:  state_d = ST_IDLE;
		endcase
		if (flush) state_d = ST_IDLE; // kills any pending issue
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state_q   <= ST_IDLE;
			exe_valid <= 1'b0;
		end else begin
			state_q   <= state_d;
			exe_valid <= issue; // single cycle pulse
		end
	end

	// Payload register
	always_ff @(posedge CLK) begin
		if (issue) exe_param <= param_d;
	end

endmodule

`default_nettype wire

// ==== hw/csr_exec.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_exec (
	input  wire                         CLK,
	input  wire                         reset,
	input  wire                         exe_valid,
	input  csr_pipe_pkg::csr_exeparam_t exe_param,
	output logic [4:0]                  rf_raddr,
	input  wire  [63:0]                 rf_rdata,
	output logic                        wb_valid,
	output csr_pipe_pkg::csr_wb_t       wb
);
	import csr_isa_pkg::*;
	import csr_pipe_pkg::*;

	logic [63:0] csr_q [4]; // mtvec, mscratch, mepc, mcause
	logic [1:0]  csr_idx;
	logic        csr_hit;
	logic [63:0] old_val, src_val, new_val;

	//////////////////////////////////////////////////
	// Address decode and read-modify-write
	//////////////////////////////////////////////////

	always_comb begin
		csr_hit = 1'b1;
		csr_idx = 2'd0;
		case (exe_param.addr)
			CSR_MTVEC:    csr_idx = 2'd0;
			CSR_MSCRATCH: csr_idx = 2'd1;
			CSR_MEPC:     csr_idx = 2'd2;
			CSR_MCAUSE:   csr_idx = 2'd3;
			default:      csr_hit = 1'b0; // unknown reads as zero
		endcase
	end

	assign rf_raddr = exe_param.rs1; // RF read port, same cycle
	assign old_val  = csr_hit ? csr_q[csr_idx] : 64'd0;
	assign src_val  = exe_param.is_imm ? {59'd0, exe_param.rs1} : rf_rdata;

	always_comb begin
		case (exe_param.func)
			FUNC_RS: new_val = old_val | src_val;
			FUNC_RC: new_val = old_val & ~src_val;
			default: new_val = src_val; // FUNC_RW
		endcase
	end

	// CSR file, writes to unknown addresses dropped
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 4; i++) csr_q[i] <= 64'd0;
		end else if (exe_valid && csr_hit) begin
			csr_q[csr_idx] <= new_val;
		end
	end

	// Writeback register
	always_ff @(posedge CLK) begin
		if (reset) wb_valid <= 1'b0;
		else       wb_valid <= exe_valid;
	end

	always_ff @(posedge CLK) begin
		if (exe_valid) begin
			wb.rd   <= exe_param.rd;
			wb.data <= old_val; // rd gets pre-update value
		end
	end

endmodule

`default_nettype wire

// ==== hw/csr_unit_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_unit_top #(
	parameter int FIFO_DEPTH = 4,
	parameter int WB_CREDITS = 2
) (
	input  wire                           CLK,
	input  wire                           reset,
	input  wire                           flush,
	input  wire                           disp_valid,
	input  csr_pipe_pkg::csr_issue_info_t disp_info,
	output logic                          disp_credit,
	input  wire  [31:0]                   wb_log,
	input  wire  [63:0]                   commit_pc,
	output logic [4:0]                    rf_raddr,
	input  wire  [63:0]                   rf_rdata,
	output logic                          wb_valid,
	output csr_pipe_pkg::csr_wb_t         wb,
	input  wire                           wb_credit
);
	import csr_pipe_pkg::*;

	logic            fifo_empty, fifo_pop;
	csr_issue_info_t fifo_head;
	logic            credit_ok, credit_take;
	logic            exe_valid;
	csr_exeparam_t   exe_param;

	//////////////////////////////////////////////////
	// Issue queue and writeback credits
	//////////////////////////////////////////////////

	csr_issue_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.CLK(CLK), .reset(reset), .flush(flush),
		.push(disp_valid), .push_info(disp_info),
		.pop(fifo_pop), .empty(fifo_empty), .head(fifo_head),
		.credit(disp_credit) // back to dispatch
	);

	csr_credit_counter #(.WB_CREDITS(WB_CREDITS)) u_credit (
		.CLK(CLK), .reset(reset),
		.take(credit_take), .give(wb_credit), .available(credit_ok)
	);

	//////////////////////////////////////////////////
	// Issue and execute
	//////////////////////////////////////////////////

	csr_issue u_issue (
		.CLK(CLK), .reset(reset), .flush(flush),
		.fifo_empty(fifo_empty), .fifo_head(fifo_head), .fifo_pop(fifo_pop),
		.wb_log(wb_log), .commit_pc(commit_pc),
		.credit_ok(credit_ok), .credit_take(credit_take),
		.exe_valid(exe_valid), .exe_param(exe_param),
		.wb_done(wb_valid) // releases ST_EXEC
	);

	csr_exec u_exec (
		.CLK(CLK), .reset(reset),
		.exe_valid(exe_valid), .exe_param(exe_param),
		.rf_raddr(rf_raddr), .rf_rdata(rf_rdata),
		.wb_valid(wb_valid), .wb(wb)
	);

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD       = 8,
	parameter int RESET_CYCLES = 8
) (
	output logic CLK,
	output logic reset
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	// Released just after an edge, like any other input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1 reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== bench/tb_csr_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_csr_unit;
	import csr_isa_pkg::*;
	import csr_pipe_pkg::*;

	localparam int FIFO_DEPTH = 4;
	localparam int WB_CREDITS = 2;
	localparam int MAX_CYCLES = 400; // all tests need about 200
	localparam int DEAD  = 0; // flushed before issue
	localparam int LIVE  = 1; // writes back as soon as ready
	localparam int GATED = 2; // writeback held until released

	logic            CLK, reset, rst_d;
	logic            flush, disp_valid, disp_credit, wb_valid, wb_credit;
	csr_issue_info_t disp_info;
	logic [31:0]     wb_log;
	logic [63:0]     commit_pc, rf_rdata, next_pc;
	logic [4:0]      rf_raddr;
	csr_wb_t         wb;

	logic [63:0] rf_model [32];
	logic [63:0] csr_model [4];  // mtvec, mscratch, mepc, mcause
	logic [11:0] addr_tab [5];
	logic [4:0]  exp_rd [64];    // expected writebacks in issue order
	logic [63:0] exp_data [64];
	logic [63:0] exp_pc [64];
	logic [4:0]  exp_rd_head;
	logic [63:0] exp_data_head;
	logic        auto_commit, hold_credit;
	int exp_head, exp_tail, allowed, credits_back, cred_seen, cred_base, disp_used, disp_avail;
	int errors, test_err0, tests, cycles, seed, sel, pick, rnd;

	tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(8)) u_clk (.CLK(CLK), .reset(reset));

	csr_unit_top #(.FIFO_DEPTH(FIFO_DEPTH), .WB_CREDITS(WB_CREDITS)) uut (
		.CLK(CLK), .reset(reset), .flush(flush),
		.disp_valid(disp_valid), .disp_info(disp_info), .disp_credit(disp_credit),
		.wb_log(wb_log), .commit_pc(commit_pc),
		.rf_raddr(rf_raddr), .rf_rdata(rf_rdata),
		.wb_valid(wb_valid), .wb(wb), .wb_credit(wb_credit)
	);

	assign rf_rdata      = rf_model[rf_raddr]; // RF read port model
	assign exp_rd_head   = exp_rd[exp_head[5:0]];
	assign exp_data_head = exp_data[exp_head[5:0]];
	assign disp_avail    = FIFO_DEPTH - disp_used + (cred_seen - cred_base);

	// Writeback and dispatch credit monitor
	always @(posedge CLK) begin
		rst_d <= reset;
		if (!reset && wb_valid)    exp_head  <= exp_head + 1;
		if (!reset && disp_credit) cred_seen <= cred_seen + 1;
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	reset_quiet: assert property (@(posedge CLK) (reset || rst_d) |-> (!wb_valid && !disp_credit))
		else begin
			errors++;
			$display("ERR t=%0t wb_valid,disp_credit exp=00 got=%b%b", $time,
			         $sampled(wb_valid), $sampled(disp_credit));
		end
	wb_permitted: assert property (@(posedge CLK) disable iff (reset) wb_valid |-> exp_head < allowed)
		else begin
			errors++;
			$display("t=%0t writeback came from a blocked, flushed or absent instruction", $time);
		end
	wb_rd_match: assert property (@(posedge CLK) disable iff (reset) wb_valid |-> wb.rd == exp_rd_head)
		else begin
			errors++;
			$display("ERR t=%0t wb.rd exp=%0d got=%0d", $time, $sampled(exp_rd_head),
			         $sampled(wb.rd));
		end
	wb_data_match: assert property (@(posedge CLK) disable iff (reset)
		wb_valid |-> wb.data == exp_data_head)
		else begin
			errors++;
			$display("ERR t=%0t wb.data exp=%h got=%h", $time, $sampled(exp_data_head),
			         $sampled(wb.data));
		end
	wb_credit_bound: assert property (@(posedge CLK) disable iff (reset)
		wb_valid |-> (exp_head - credits_back) < WB_CREDITS)
		else begin
			errors++;
			$display("t=%0t writeback issued with no writeback credit left", $time);
		end
	disp_credit_once: assert property (@(posedge CLK) disable iff (reset)
		disp_credit |-> cred_seen == exp_head)
		else begin
			errors++;
			$display("ERR t=%0t disp_credit count exp=%0d got=%0d", $time, $sampled(exp_head),
			         $sampled(cred_seen));
		end
	disp_credit_before_wb: assert property (@(posedge CLK) disable iff (reset)
		wb_valid |-> cred_seen == exp_head + 1)
		else begin
			errors++;
			$display("ERR t=%0t disp_credit count exp=%0d got=%0d", $time,
			         $sampled(exp_head) + 1, $sampled(cred_seen));
		end
	disp_range: assert property (@(posedge CLK) disable iff (reset)
		disp_avail >= 0 && disp_avail <= FIFO_DEPTH)
		else begin
			errors++;
			$display("t=%0t dispatch credit count left the range 0 to %0d", $time, FIFO_DEPTH);
		end

	//////////////////////////////////////////////////
	// Reference model and stimulus
	//////////////////////////////////////////////////

	function automatic int csr_slot(input logic [11:0] addr);
		case (addr)
			CSR_MTVEC:    return 0;
			CSR_MSCRATCH: return 1;
			CSR_MEPC:     return 2;
			CSR_MCAUSE:   return 3;
			default:      return -1; // unimplemented
		endcase
	endfunction

	function automatic logic is_imm_op(input csr_op_e op);
		return op inside {CSRRWI, CSRRSI, CSRRCI};
	endfunction

	function automatic logic [63:0] csr_next(input csr_op_e op, input logic [63:0] old,
	                                         input logic [63:0] src);
		case (op)
			CSRRW, CSRRWI: return src;
			CSRRS, CSRRSI: return old | src;
			default:       return old & ~src; // clear forms
		endcase
	endfunction

	// One cycle; commit stage and writeback consumer act here
	task automatic step();
		@(posedge CLK);
		#1;
		disp_valid = 1'b0;
		flush      = 1'b0;
		if (auto_commit && exp_head < exp_tail) commit_pc = exp_pc[exp_head[5:0]];
		if (!hold_credit && exp_head > credits_back) begin
			wb_credit = 1'b1;
			credits_back++;
		end else begin
			wb_credit = 1'b0;
		end
	endtask

	task automatic dispatch(input csr_op_e op, input logic [11:0] addr, input logic [4:0] rd,
	                        input logic [4:0] rs1, input int kind);
		int          slot;
		logic [63:0] old, src;
		while (disp_avail <= 0) step(); // stall on dispatch credits
		disp_info  = '{op: op, pc: next_pc, addr: addr, rd: rd, rs1: rs1};
		disp_valid = 1'b1;
		disp_used++;
		if (kind != DEAD) begin
			slot = csr_slot(addr);
			old  = (slot < 0) ? 64'd0 : csr_model[slot[1:0]];
			src  = is_imm_op(op) ? {59'd0, rs1} : rf_model[rs1];
			exp_rd[exp_tail[5:0]]   = rd;
			exp_data[exp_tail[5:0]] = old; // rd gets pre-update value
			exp_pc[exp_tail[5:0]]   = next_pc;
			if (slot >= 0) csr_model[slot[1:0]] = csr_next(op, old, src);
			exp_tail++;
			if (kind == LIVE) allowed++;
		end
		next_pc += 64'd4;
		step();
	endtask

	task automatic drain();
		while (exp_head < allowed || credits_back < exp_head) step();
	endtask

	task automatic report(input string name);
		$display("test %-9s %0d new errors, %0d writebacks so far", name, errors - test_err0,
		         exp_head);
		tests++;
		test_err0 = errors;
	endtask

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge CLK);
			cycles++;
		end
		$display("timeout: run still going after %0d cycles", cycles);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		seed = 42412;
		flush = 1'b0;
		disp_valid = 1'b0;
		disp_info = '0;
		wb_log = '1;
		commit_pc = 64'd0;
		wb_credit = 1'b0;
		auto_commit = 1'b1;
		hold_credit = 1'b0;
		next_pc = 64'h8000_0100;
		errors = 0;
		test_err0 = 0;
		tests = 0;
		for (int i = 0; i < 32; i++) rf_model[i] = {$random(seed), $random(seed)};
		rf_model[0] = 64'd0; // x0
		for (int i = 0; i < 4; i++) csr_model[i] = 64'd0;
		addr_tab = '{CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, 12'h7c0};

		@(negedge reset);
		repeat (3) step();
		report("reset");

		auto_commit = 1'b0; // older instruction not yet retired
		dispatch(CSRRW, CSR_MSCRATCH, 5'd1, 5'd3, GATED);
		repeat (6) step();
		commit_pc = exp_pc[exp_head[5:0]];
		allowed++;
		auto_commit = 1'b1;
		drain();
		report("ordering");

		wb_log[7] = 1'b0; // x7 still in flight
		wb_log[0] = 1'b0; // x0 bit is don't care
		dispatch(CSRRS, CSR_MSCRATCH, 5'd2, 5'd0, LIVE);
		dispatch(CSRRSI, CSR_MSCRATCH, 5'd3, 5'd7, LIVE);
		dispatch(CSRRC, CSR_MSCRATCH, 5'd4, 5'd7, GATED);
		repeat (12) step();
		if (exp_head != allowed) begin
			errors++;
			$display("ERR t=%0t wb_valid count exp=%0d got=%0d", $time, allowed, exp_head);
		end
		wb_log = '1;
		allowed++;
		drain();
		report("operand");

		for (int i = 0; i < 12; i++) begin
			sel  = $unsigned($random(seed)) % 6;
			pick = $unsigned($random(seed)) % 5;
			rnd  = $random(seed);
			dispatch(csr_op_e'(sel[2:0]), addr_tab[pick[2:0]], rnd[4:0], rnd[9:5], LIVE);
		end
		dispatch(CSRRWI, CSR_MEPC, 5'd5, 5'h15, LIVE); // back to back on mepc
		dispatch(CSRRS, CSR_MEPC, 5'd6, 5'd0, LIVE);
		drain();
		report("csr_rmw");

		hold_credit = 1'b1; // consumer stops draining
		for (int i = 0; i < 6; i++) dispatch(CSRRSI, CSR_MCAUSE, 5'(i + 10), 5'(i + 1), LIVE);
		repeat (10) step();
		if (exp_head - credits_back != WB_CREDITS) begin
			errors++;
			$display("ERR t=%0t wb_valid count exp=%0d got=%0d", $time, WB_CREDITS,
			         exp_head - credits_back);
		end
		hold_credit = 1'b0;
		drain();
		report("credits");

		auto_commit = 1'b0;
		commit_pc = 64'd0; // head never ready, entries stay queued
		for (int i = 0; i < 3; i++) dispatch(CSRRW, CSR_MTVEC, 5'd20, 5'd1, DEAD);
		repeat (3) step();
		flush = 1'b1;
		step();
		disp_used = 0; // queue empty again, full dispatch credit
		cred_base = cred_seen;
		auto_commit = 1'b1;
		dispatch(CSRRS, CSR_MTVEC, 5'd21, 5'd0, LIVE);
		dispatch(CSRRCI, CSR_MTVEC, 5'd22, 5'h03, LIVE);
		drain();
		report("flush");

		repeat (2) step();
		$display("summary: %0d tests, %0d writebacks, %0d errors", tests, exp_head, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== csr_unit.f ====
hw/csr_isa_pkg.sv
hw/csr_pipe_pkg.sv
hw/csr_issue_fifo.sv
hw/csr_credit_counter.sv
hw/csr_issue.sv
hw/csr_exec.sv
hw/csr_unit_top.sv
bench/tb_clock_gen.sv
bench/tb_csr_unit.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP      = tb_csr_unit
FILELIST = csr_unit.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
